/* design/rv_exec_macros.svh */
`ifndef RV_EXEC_MACROS_SVH
`define RV_EXEC_MACROS_SVH

// datapath width of the RV32 slice
`define RV_XLEN 32

// architectural registers, 16 for an RV32E build
`define RV_REG_COUNT 32

// register specifier width in the instruction word
`define RV_REG_IDX_W 5

`endif

/* design/rv_isa_pkg.sv */
package rv_isa_pkg;

	typedef enum logic [6:0] {
		opc_op     = 7'b0110011,
		opc_op_imm = 7'b0010011,
		opc_lui    = 7'b0110111,
		opc_auipc  = 7'b0010111,
		opc_jal    = 7'b1101111,
		opc_jalr   = 7'b1100111,
		opc_branch = 7'b1100011,
		opc_store  = 7'b0100011,
		opc_system = 7'b1110011
	} opcode_e;

	typedef enum logic [2:0] {
		type_r = 3'd0,
		type_i = 3'd1,
		type_s = 3'd2,
		type_b = 3'd3,
		type_u = 3'd4,
		type_j = 3'd5
	} inst_type_e;

	typedef enum logic [3:0] {
		alu_add   = 4'd0,
		alu_sub   = 4'd1,
		alu_and   = 4'd2,
		alu_xor   = 4'd3,
		alu_or    = 4'd4,
		alu_srl   = 4'd5,
		alu_sra   = 4'd6,
		alu_sll   = 4'd7,
		alu_less  = 4'd8,
		alu_uless = 4'd9
	} alu_op_e;

	typedef enum logic [11:0] {
		csr_mstatus = 12'h300,
		csr_mtvec   = 12'h305,
		csr_mepc    = 12'h341,
		csr_mcause  = 12'h342
	} csr_addr_e;

	localparam logic [2:0] f3_beq   = 3'b000;
	localparam logic [2:0] f3_bne   = 3'b001;
	localparam logic [2:0] f3_blt   = 3'b100;
	localparam logic [2:0] f3_bge   = 3'b101;
	localparam logic [2:0] f3_bltu  = 3'b110;
	localparam logic [2:0] f3_bgeu  = 3'b111;
	localparam logic [2:0] f3_sb    = 3'b000;
	localparam logic [2:0] f3_sh    = 3'b001;
	localparam logic [2:0] f3_sw    = 3'b010;
	localparam logic [2:0] f3_csrrw = 3'b001;
	localparam logic [2:0] f3_csrrs = 3'b010;

endpackage

/* design/rv_exec_pkg.sv */
`include "rv_exec_macros.svh"

package rv_exec_pkg;

	typedef struct packed {
		logic [`RV_XLEN-1:0] pc;
		logic [31:0]         instr;
	} inst_in_t;

	typedef struct packed {
		logic [`RV_XLEN-1:0]      pc;
		rv_isa_pkg::opcode_e      opcode;
		rv_isa_pkg::inst_type_e   inst_type;
		logic [2:0]               funct3;
		logic [6:0]               funct7;
		logic [`RV_REG_IDX_W-1:0] rd;
		logic [`RV_REG_IDX_W-1:0] rs1;
		logic [`RV_REG_IDX_W-1:0] rs2;
		logic [`RV_XLEN-1:0]      imm;
		rv_isa_pkg::csr_addr_e    csr_addr;
		logic                     rd_we;
		logic                     csr_we;
	} decoded_t;

	typedef struct packed {
		logic [`RV_XLEN-1:0] val;
		logic [`RV_XLEN-1:0] next_pc;
		logic                mem_we;
		logic [3:0]          wmask;
		logic [`RV_XLEN-1:0] csr_wdata;
	} exu_result_t;

	typedef struct packed {
		logic [`RV_XLEN-1:0]      pc;
		logic [`RV_REG_IDX_W-1:0] rd;
		logic                     rd_we;
		logic [`RV_XLEN-1:0]      rd_wdata;
		logic [`RV_XLEN-1:0]      next_pc;
		logic                     mem_we;
		logic [`RV_XLEN-1:0]      mem_addr;
		logic [`RV_XLEN-1:0]      mem_wdata;
		logic [3:0]               wmask;
	} commit_t;

	typedef enum logic [1:0] {
		st_idle    = 2'd0,
		st_exec    = 2'd1,
		st_hold    = 2'd2,
		st_release = 2'd3
	} ctrl_state_e;

endpackage

/* design/rv_idu.sv */
`include "rv_exec_macros.svh"

module rv_idu (
	input  logic [31:0]           instr,
	input  logic [`RV_XLEN-1:0]   pc,
	output rv_exec_pkg::decoded_t dec
);

	import rv_isa_pkg::*;

	opcode_e             opcode;
	inst_type_e          inst_type;
	logic [2:0]          funct3;
	logic [`RV_XLEN-1:0] imm_i;
	logic [`RV_XLEN-1:0] imm_s;
	logic [`RV_XLEN-1:0] imm_b;
	logic [`RV_XLEN-1:0] imm_u;
	logic [`RV_XLEN-1:0] imm_j;
	logic                is_csr;

	assign opcode = opcode_e'(instr[6:0]);
	assign funct3 = instr[14:12];

	assign imm_i = {{20{instr[31]}}, instr[31:20]};
	assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
	assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
	assign imm_u = {instr[31:12], 12'b0};
	assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

	always_comb begin
		case (opcode)
			opc_op:                         inst_type = type_r;
			opc_op_imm, opc_jalr, opc_system: inst_type = type_i;
			opc_store:                      inst_type = type_s;
			opc_branch:                     inst_type = type_b;
			opc_lui, opc_auipc:             inst_type = type_u;
			opc_jal:                        inst_type = type_j;
			default:                        inst_type = type_r; // unknown, no writes
		endcase
	end

	// only the register forms of csrrw/csrrs are supported
	assign is_csr = (opcode == opc_system) && (funct3 == f3_csrrw || funct3 == f3_csrrs);

	always_comb begin
		case (opcode)
			opc_op, opc_op_imm, opc_lui, opc_auipc, opc_jal, opc_jalr: dec.rd_we = 1'b1;
			opc_system: dec.rd_we = is_csr && (instr[11:7] != '0);
			default:    dec.rd_we = 1'b0;
		endcase
	end

	always_comb begin
		case (inst_type)
			type_i:  dec.imm = imm_i;
			type_s:  dec.imm = imm_s;
			type_b:  dec.imm = imm_b;
			type_u:  dec.imm = imm_u;
			type_j:  dec.imm = imm_j;
			default: dec.imm = '0; // r-type has none
		endcase
	end

	assign dec.pc        = pc;
	assign dec.opcode    = opcode;
	assign dec.inst_type = inst_type;
	assign dec.funct3    = funct3;
	assign dec.funct7    = instr[31:25];
	assign dec.rd        = instr[11:7];
	assign dec.rs1       = instr[19:15];
	assign dec.rs2       = instr[24:20];
	assign dec.csr_addr  = csr_addr_e'(instr[31:20]);
	assign dec.csr_we    = is_csr;

endmodule

/* design/rv_regfile.sv */
`include "rv_exec_macros.svh"

module rv_regfile #(
	parameter int REG_COUNT = `RV_REG_COUNT
) (
	input  logic                     clk,
	input  logic                     rst_n,
	input  logic [`RV_REG_IDX_W-1:0] raddr1,
	input  logic [`RV_REG_IDX_W-1:0] raddr2,
	output logic [`RV_XLEN-1:0]      rdata1,
	output logic [`RV_XLEN-1:0]      rdata2,
	input  logic                     we,
	input  logic [`RV_REG_IDX_W-1:0] waddr,
	input  logic [`RV_XLEN-1:0]      wdata
);

	logic [`RV_XLEN-1:0] regs [REG_COUNT];

	// indices past REG_COUNT read as zero on rv32e
	assign rdata1 = (raddr1 < REG_COUNT) ? regs[raddr1] : '0;
	assign rdata2 = (raddr2 < REG_COUNT) ? regs[raddr2] : '0;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < REG_COUNT; i++) begin
				regs[i] <= '0;
			end
		end else if (we && waddr != '0 && waddr < REG_COUNT) begin // x0 writes dropped
			regs[waddr] <= wdata;
		end
	end

	x0_read1_zero: assert property (@(posedge clk) disable iff (!rst_n)
		(raddr1 == '0) |-> (rdata1 == '0));
	x0_read2_zero: assert property (@(posedge clk) disable iff (!rst_n)
		(raddr2 == '0) |-> (rdata2 == '0));

endmodule

/* design/rv_csr_file.sv */
`include "rv_exec_macros.svh"

module rv_csr_file (
	input  logic                  clk,
	input  logic                  rst_n,
	input  rv_isa_pkg::csr_addr_e addr,
	output logic [`RV_XLEN-1:0]   rdata,
	input  logic                  we,
	input  logic [`RV_XLEN-1:0]   wdata
);

	import rv_isa_pkg::*;

	logic [`RV_XLEN-1:0] mstatus;
	logic [`RV_XLEN-1:0] mtvec;
	logic [`RV_XLEN-1:0] mepc;
	logic [`RV_XLEN-1:0] mcause;

	always_comb begin
		case (addr)
			csr_mstatus: rdata = mstatus;
			csr_mtvec:   rdata = mtvec;
			csr_mepc:    rdata = mepc;
			csr_mcause:  rdata = mcause;
			default:     rdata = '0; // unimplemented csr
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			mstatus <= '0;
			mtvec   <= '0;
			mepc    <= '0;
			mcause  <= '0;
		end else if (we) begin
			case (addr)
				csr_mstatus: mstatus <= wdata;
				csr_mtvec:   mtvec   <= wdata;
				csr_mepc:    mepc    <= wdata;
				csr_mcause:  mcause  <= wdata;
				default:     ;
			endcase
		end
	end

endmodule

/* design/rv_exu.sv */
`include "rv_exec_macros.svh"

module rv_exu (
	input  rv_exec_pkg::decoded_t    dec,
	input  logic [`RV_XLEN-1:0]      src1,
	input  logic [`RV_XLEN-1:0]      src2,
	input  logic [`RV_XLEN-1:0]      csr_val,
	output rv_exec_pkg::exu_result_t res
);

	import rv_isa_pkg::*;

	logic [`RV_XLEN-1:0] lop;
	logic [`RV_XLEN-1:0] rop;
	logic [4:0]          shamt;
	alu_op_e             alu_op;
	logic [`RV_XLEN-1:0] alu_val;
	logic [`RV_XLEN-1:0] pc_plus4;
	logic [`RV_XLEN-1:0] pc_rel;
	logic [`RV_XLEN-1:0] reg_rel;
	logic                br_taken;
	logic                is_store;

	always_comb begin
		case (dec.opcode)
			opc_lui:                    lop = '0;
			opc_auipc, opc_jal, opc_jalr: lop = dec.pc;
			opc_op, opc_op_imm, opc_store: lop = src1;
			default:                    lop = '0;
		endcase
	end

	always_comb begin
		case (dec.opcode)
			opc_lui, opc_auipc, opc_op_imm: rop = dec.imm;
			opc_jal, opc_jalr:            rop = 4; // link value
			opc_op:                       rop = src2;
			opc_store:                    rop = dec.imm; // effective address
			default:                      rop = '0;
		endcase
	end

	always_comb begin
		alu_op = alu_add;
		if (dec.inst_type == type_r || dec.inst_type == type_i) begin
			case (dec.funct3)
				3'b000:  alu_op = (dec.inst_type == type_r && dec.funct7[5]) ? alu_sub : alu_add;
				3'b001:  alu_op = alu_sll;
				3'b010:  alu_op = alu_less;
				3'b011:  alu_op = alu_uless;
				3'b100:  alu_op = alu_xor;
				3'b101:  alu_op = dec.funct7[5] ? alu_sra : alu_srl;
				3'b110:  alu_op = alu_or;
				default: alu_op = alu_and;
			endcase
		end
	end

	assign shamt = rop[4:0];

	always_comb begin
		case (alu_op)
			alu_add:   alu_val = lop + rop;
			alu_sub:   alu_val = lop - rop;
			alu_and:   alu_val = lop & rop;
			alu_xor:   alu_val = lop ^ rop;
			alu_or:    alu_val = lop | rop;
			alu_srl:   alu_val = lop >> shamt;
			alu_sra:   alu_val = $signed(lop) >>> shamt;
			alu_sll:   alu_val = lop << shamt;
			alu_less:  alu_val = {{(`RV_XLEN-1){1'b0}}, $signed(lop) < $signed(rop)};
			alu_uless: alu_val = {{(`RV_XLEN-1){1'b0}}, lop < rop};
			default:   alu_val = '0;
		endcase
	end

	always_comb begin
		case (dec.funct3)
			f3_beq:  br_taken = (src1 == src2);
			f3_bne:  br_taken = (src1 != src2);
			f3_blt:  br_taken = $signed(src1) < $signed(src2);
			f3_bge:  br_taken = $signed(src1) >= $signed(src2);
			f3_bltu: br_taken = src1 < src2;
			f3_bgeu: br_taken = src1 >= src2;
			default: br_taken = 1'b0;
		endcase
	end

	assign pc_plus4 = dec.pc + 4;
	assign pc_rel   = dec.pc + dec.imm;
	assign reg_rel  = src1 + dec.imm;

	always_comb begin
		case (dec.opcode)
			opc_jal:    res.next_pc = pc_rel;
			opc_jalr:   res.next_pc = {reg_rel[`RV_XLEN-1:1], 1'b0};
			opc_branch: res.next_pc = br_taken ? pc_rel : pc_plus4;
			default:    res.next_pc = pc_plus4;
		endcase
	end

	assign is_store = (dec.opcode == opc_store);

	always_comb begin
		case (dec.funct3)
			f3_sb:   res.wmask = is_store ? 4'h1 : 4'h0;
			f3_sh:   res.wmask = is_store ? 4'h3 : 4'h0;
			f3_sw:   res.wmask = is_store ? 4'hf : 4'h0;
			default: res.wmask = 4'h0;
		endcase
	end

	always_comb begin
		case (dec.funct3)
			f3_csrrw: res.csr_wdata = src1;
			f3_csrrs: res.csr_wdata = src1 | csr_val;
			default:  res.csr_wdata = '0;
		endcase
	end

	assign res.mem_we = is_store;
	assign res.val    = (dec.opcode == opc_system) ? csr_val : alu_val; // old csr goes to rd

endmodule

/* design/rv_exec_ctrl.sv */
`include "rv_exec_macros.svh"

module rv_exec_ctrl (
	input  logic                     clk,
	input  logic                     rst_n,
	input  logic                     inst_req,
	output logic                     inst_ack,
	input  rv_exec_pkg::inst_in_t    inst,
	output logic [31:0]              instr_q,
	output logic [`RV_XLEN-1:0]      pc_q,
	input  rv_exec_pkg::decoded_t    dec,
	input  logic [`RV_XLEN-1:0]      src2,
	input  rv_exec_pkg::exu_result_t res,
	output logic                     rf_we,
	output logic                     csr_we,
	output logic                     commit_req,
	input  logic                     commit_ack,
	output rv_exec_pkg::commit_t     commit
);

	import rv_exec_pkg::*;

	ctrl_state_e state;
	logic        req_q; // req sampled at edge n, acted on at n+1
	inst_in_t    inst_q;

	assign instr_q = inst_q.instr;
	assign pc_q    = inst_q.pc;
	assign rf_we   = (state == st_exec) && dec.rd_we;
	assign csr_we  = (state == st_exec) && dec.csr_we;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state      <= st_idle;
			req_q      <= 1'b0;
			inst_ack   <= 1'b0;
			commit_req <= 1'b0;
		end else begin
			req_q <= inst_req;
			case (state)
				st_idle: if (req_q) state <= st_exec;
				st_exec: begin
					state      <= st_hold;
					inst_ack   <= 1'b1;
					commit_req <= 1'b1;
				end
				st_hold: if (!inst_req && commit_ack) begin // both sides done
					state      <= st_release;
					inst_ack   <= 1'b0;
					commit_req <= 1'b0;
				end
				st_release: if (!commit_ack) state <= st_idle;
				default: state <= st_idle;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == st_idle && req_q) inst_q <= inst;
		if (state == st_exec) begin
			commit.pc        <= inst_q.pc;
			commit.rd        <= dec.rd;
			commit.rd_we     <= dec.rd_we;
			commit.rd_wdata  <= res.val;
			commit.next_pc   <= res.next_pc;
			commit.mem_we    <= res.mem_we;
			commit.mem_addr  <= res.val;
			commit.mem_wdata <= src2;
			commit.wmask     <= res.wmask;
		end
	end

	commit_stable: assert property (@(posedge clk) disable iff (!rst_n)
		(commit_req && !commit_ack) |=> $stable(commit));
	ack_after_req: assert property (@(posedge clk) disable iff (!rst_n)
		$rose(inst_ack) |-> $past(inst_req));

endmodule

/* design/rv_exec_top.sv */
`include "rv_exec_macros.svh"

module rv_exec_top (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  inst_req,
	output logic                  inst_ack,
	input  rv_exec_pkg::inst_in_t inst,
	output logic                  commit_req,
	input  logic                  commit_ack,
	output rv_exec_pkg::commit_t  commit
);

	import rv_exec_pkg::*;

	logic [31:0]         instr_q;
	logic [`RV_XLEN-1:0] pc_q;
	decoded_t            dec;
	logic [`RV_XLEN-1:0] src1;
	logic [`RV_XLEN-1:0] src2;
	logic [`RV_XLEN-1:0] csr_val;
	exu_result_t         res;
	logic                rf_we;
	logic                csr_we;

	rv_exec_ctrl ctrl_i (
		.clk(clk), .rst_n(rst_n),
		.inst_req(inst_req), .inst_ack(inst_ack), .inst(inst),
		.instr_q(instr_q), .pc_q(pc_q),
		.dec(dec), .src2(src2), .res(res),
		.rf_we(rf_we), .csr_we(csr_we),
		.commit_req(commit_req), .commit_ack(commit_ack), .commit(commit)
	);

	rv_idu idu_i (.instr(instr_q), .pc(pc_q), .dec(dec));

	rv_regfile #(.REG_COUNT(`RV_REG_COUNT)) regfile_i (
		.clk(clk), .rst_n(rst_n),
		.raddr1(dec.rs1), .raddr2(dec.rs2), .rdata1(src1), .rdata2(src2),
		.we(rf_we), .waddr(dec.rd), .wdata(res.val)
	);

	rv_csr_file csr_i (
		.clk(clk), .rst_n(rst_n), .addr(dec.csr_addr), .rdata(csr_val),
		.we(csr_we), .wdata(res.csr_wdata)
	);

	rv_exu exu_i (.dec(dec), .src1(src1), .src2(src2), .csr_val(csr_val), .res(res));

endmodule

/* verif/rv_exec_clkgen.sv */
module rv_exec_clkgen #(
	parameter int PERIOD       = 20,
	parameter int RESET_CYCLES = 8
) (
	output logic clk,
	output logic rst_n
);

	timeunit 1ns;
	timeprecision 100ps;

	initial clk = 1'b0;
	always #(PERIOD / 2) clk = ~clk;

	initial begin
		rst_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1; // released away from the active edge
	end

endmodule

/* verif/rv_exec_tb.sv */
module rv_exec_tb;

	timeunit 1ns;
	timeprecision 100ps;

	import rv_isa_pkg::*;
	import rv_exec_pkg::*;

	localparam int RESET_CYCLES = 8;
	localparam int N_INSTR      = 200; // upper bound of instructions over all tests
	localparam int MAX_CYCLES   = RESET_CYCLES + 20 * N_INSTR;

	logic     clk;
	logic     rst_n;
	logic     inst_req;
	logic     inst_ack;
	inst_in_t inst;
	logic     commit_req;
	logic     commit_ack;
	commit_t  commit;

	logic [31:0] model_regs [32];
	logic [31:0] model_csr [4];
	commit_t     exp_q [$];
	commit_t     exp_c;
	integer      seed = 32'h80d0722f;
	int          errors = 0;
	int          n_checks = 0;
	int          n_sent = 0;
	int          ack_rises = 0;
	int          cycles = 0;
	int          test_errs;
	string       test_name;
	logic        seen = 1'b0;
	logic        ack_prev = 1'b0;
	logic        hold_ack = 1'b0;
	logic [31:0] cur_pc = 32'h0000_1000;

	rv_exec_clkgen #(.PERIOD(20), .RESET_CYCLES(RESET_CYCLES)) clkgen_i (
		.clk(clk), .rst_n(rst_n)
	);

	rv_exec_top dut_i (
		.clk(clk), .rst_n(rst_n),
		.inst_req(inst_req), .inst_ack(inst_ack), .inst(inst),
		.commit_req(commit_req), .commit_ack(commit_ack), .commit(commit)
	);

	function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
		return {f7, rs2, rs1, f3, rd, opc_op};
	endfunction

	function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
		input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] opc);
		return {imm, rs1, f3, rd, opc};
	endfunction

	function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3);
		return {imm[11:5], rs2, rs1, f3, imm[4:0], opc_store};
	endfunction

	function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3);
		return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], opc_branch};
	endfunction

	function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd, opc_jal};
	endfunction

	function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
		input logic [31:0] x, input logic [31:0] y);
		case (f3)
			3'd0: return alt ? x - y : x + y;
			3'd1: return x << y[4:0];
			3'd2: return {31'b0, $signed(x) < $signed(y)};
			3'd3: return {31'b0, x < y};
			3'd4: return x ^ y;
			3'd5: begin
				if (alt) return $signed(x) >>> y[4:0];
				else return x >> y[4:0];
			end
			3'd6: return x | y;
			default: return x & y;
		endcase
	endfunction

	function automatic int csr_index(input logic [11:0] addr);
		case (addr)
			12'h300: return 0;
			12'h305: return 1;
			12'h341: return 2;
			12'h342: return 3;
			default: return -1; // unimplemented
		endcase
	endfunction

	// expected commit record from the ISA rules and the model state
	function automatic commit_t ref_commit(input inst_in_t x);
		commit_t     c;
		logic [31:0] w;
		logic [2:0]  f3;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] imm_i;
		logic [31:0] imm_s;
		logic [31:0] imm_b;
		logic [31:0] v;
		logic        taken;
		int          ci;
		w     = x.instr;
		f3    = w[14:12];
		a     = model_regs[w[19:15]];
		b     = model_regs[w[24:20]];
		imm_i = {{20{w[31]}}, w[31:20]};
		imm_s = {{20{w[31]}}, w[31:25], w[11:7]};
		imm_b = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
		c           = '0;
		c.pc        = x.pc;
		c.rd        = w[11:7];
		c.next_pc   = x.pc + 4;
		c.mem_wdata = b;
		v           = '0;
		case (w[6:0])
			opc_op: begin
				c.rd_we = 1'b1;
				v = alu_ref(f3, w[30], a, b);
			end
			opc_op_imm: begin
				c.rd_we = 1'b1;
				v = alu_ref(f3, (f3 == 3'd5) && w[30], a, imm_i);
			end
			opc_lui: begin
				c.rd_we = 1'b1;
				v = {w[31:12], 12'b0};
			end
			opc_auipc: begin
				c.rd_we = 1'b1;
				v = x.pc + {w[31:12], 12'b0};
			end
			opc_jal: begin
				c.rd_we = 1'b1;
				v = x.pc + 4;
				c.next_pc = x.pc + {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
			end
			opc_jalr: begin
				c.rd_we = 1'b1;
				v = x.pc + 4;
				c.next_pc = (a + imm_i) & ~32'd1;
			end
			opc_branch: begin
				case (f3)
					3'b000: taken = a == b;
					3'b001: taken = a != b;
					3'b100: taken = $signed(a) < $signed(b);
					3'b101: taken = $signed(a) >= $signed(b);
					3'b110: taken = a < b;
					3'b111: taken = a >= b;
					default: taken = 1'b0;
				endcase
				if (taken) c.next_pc = x.pc + imm_b;
			end
			opc_store: begin
				c.mem_we = 1'b1;
				v = a + imm_s;
				c.wmask = (f3 == 3'd0) ? 4'h1 : (f3 == 3'd1) ? 4'h3 : (f3 == 3'd2) ? 4'hf : 4'h0;
			end
			opc_system: begin
				ci = csr_index(w[31:20]);
				v = (ci < 0) ? '0 : model_csr[ci];
				c.rd_we = (f3 == 3'd1 || f3 == 3'd2) && (w[11:7] != 0);
			end
			default: ;
		endcase
		c.rd_wdata = v;
		c.mem_addr = v;
		return c;
	endfunction

	task automatic step_model(input inst_in_t x, output commit_t c);
		logic [31:0] a;
		int          ci;
		c  = ref_commit(x);
		a  = model_regs[x.instr[19:15]];
		ci = csr_index(x.instr[31:20]);
		if (x.instr[6:0] == opc_system && ci >= 0) begin
			if (x.instr[14:12] == 3'd1) model_csr[ci] = a;
			if (x.instr[14:12] == 3'd2) model_csr[ci] = a | model_csr[ci];
		end
		if (c.rd_we && c.rd != 0) model_regs[c.rd] = c.rd_wdata;
	endtask

	task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
		n_checks++;
		assert (exp === act) else begin
			$display("** Error: %s expected %h got %h", name, exp, act);
			errors++;
		end
	endtask

	task automatic raise_req(input logic [31:0] instr);
		inst_in_t x;
		commit_t  e;
		x.pc    = cur_pc;
		x.instr = instr;
		cur_pc  = cur_pc + 4;
		step_model(x, e);
		exp_q.push_back(e);
		n_sent++;
		@(negedge clk);
		inst     = x;
		inst_req = 1'b1;
	endtask

	task automatic send(input logic [31:0] instr);
		raise_req(instr);
		while (!inst_ack) @(negedge clk);
		inst_req = 1'b0;
		while (inst_ack || commit_ack) @(negedge clk);
	endtask

	task automatic load_const(input logic [4:0] rd, input logic [31:0] v);
		logic [31:0] upper;
		upper = (v + 32'h800) >> 12;
		send({upper[19:0], rd, opc_lui});
		send(enc_i(v[11:0], rd, 3'd0, rd, opc_op_imm));
	endtask

	task automatic begin_test(input string name);
		test_name = name;
		test_errs = errors;
	endtask

	task automatic end_test;
		if (errors == test_errs) $display("test %s: pass", test_name);
		else $display("test %s: FAIL with %0d errors", test_name, errors - test_errs);
	endtask

	always @(negedge clk) begin
		if (rst_n && commit_req && !seen) begin
			seen = 1'b1;
			if (exp_q.size() == 0) begin
				$display("commit arrived with no instruction outstanding");
				errors++;
			end else begin
				exp_c = exp_q.pop_front();
				check_value("commit.pc", exp_c.pc, commit.pc);
				check_value("commit.rd", exp_c.rd, commit.rd);
				check_value("commit.rd_we", exp_c.rd_we, commit.rd_we);
				check_value("commit.rd_wdata", exp_c.rd_wdata, commit.rd_wdata);
				check_value("commit.next_pc", exp_c.next_pc, commit.next_pc);
				check_value("commit.mem_we", exp_c.mem_we, commit.mem_we);
				check_value("commit.mem_addr", exp_c.mem_addr, commit.mem_addr);
				check_value("commit.mem_wdata", exp_c.mem_wdata, commit.mem_wdata);
				check_value("commit.wmask", exp_c.wmask, commit.wmask);
			end
		end
		if (!commit_req) seen = 1'b0;
		if (inst_ack && !ack_prev) ack_rises++;
		ack_prev = inst_ack;
	end

	// commit sink with random answer delay
	initial begin
		int d;
		commit_ack = 1'b0;
		forever begin
			@(negedge clk);
			if (commit_req && !commit_ack && !hold_ack) begin
				d = $unsigned($random(seed)) % 6;
				repeat (d) @(negedge clk);
				commit_ack = 1'b1;
			end else if (!commit_req && commit_ack && !hold_ack) begin
				commit_ack = 1'b0;
			end
		end
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles >= MAX_CYCLES) begin
			$display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
			$display("Something failed");
			$finish;
		end
	end

	initial begin
		logic [31:0] r1;
		logic [31:0] r2;
		logic [11:0] im;
		logic [4:0]  sa;
		logic [4:0]  b1 [12];
		logic [4:0]  b2 [12];
		commit_t     c0;
		int          k;
		inst_req = 1'b0;
		inst     = '0;
		for (int i = 0; i < 32; i++) model_regs[i] = '0;
		for (int i = 0; i < 4; i++) model_csr[i] = '0;
		@(posedge rst_n);
		@(negedge clk);

		begin_test("reset state");
		check_value("inst_ack", 0, inst_ack);
		check_value("commit_req", 0, commit_req);
		for (int r = 1; r < 32; r++) send(enc_s(12'h0, r[4:0], 5'd0, f3_sw));
		end_test();

		begin_test("alu ops");
		for (int round = 0; round < 4; round++) begin
			load_const(5'd1, $random(seed));
			load_const(5'd2, $random(seed));
			load_const(5'd3, $random(seed) | 32'h8000_0000); // negative operand
			load_const(5'd4, $random(seed) & 32'h0000_00ff);
			r1 = (round % 2) ? 32'd3 : 32'd1;
			r2 = (round % 2) ? 32'd4 : 32'd2;
			for (int f = 0; f < 8; f++) begin
				send(enc_r(7'h00, r2[4:0], r1[4:0], f[2:0], 5'd10 + f[4:0]));
			end
			send(enc_r(7'h20, r2[4:0], r1[4:0], 3'd0, 5'd18)); // sub
			send(enc_r(7'h20, r2[4:0], r1[4:0], 3'd5, 5'd19)); // sra
			for (int f = 0; f < 8; f++) begin
				im = $random(seed);
				sa = $random(seed);
				if (f == 1 || f == 5) im = {7'h00, sa};
				send(enc_i(im, r1[4:0], f[2:0], 5'd20 + f[4:0], opc_op_imm));
			end
			sa = $random(seed);
			send(enc_i({7'h20, sa}, r1[4:0], 3'd5, 5'd28, opc_op_imm)); // srai
		end
		end_test();

		begin_test("upper and jumps");
		load_const(5'd1, 32'h0000_2000);
		r1 = $random(seed);
		send({r1[19:0], 5'd20, opc_lui});
		r1 = $random(seed);
		send({r1[19:0], 5'd21, opc_auipc});
		r1 = $random(seed);
		send(enc_j({r1[19:0], 1'b0}, 5'd22));
		send(enc_j(21'h1f_fff0, 5'd23)); // backward
		send(enc_i(12'h005, 5'd1, 3'd0, 5'd24, opc_jalr)); // odd target
		send(enc_i(12'hff8, 5'd1, 3'd0, 5'd25, opc_jalr));
		end_test();

		begin_test("branches");
		load_const(5'd5, 32'hffff_fffd);
		load_const(5'd6, 32'd5);
		load_const(5'd7, 32'd5);
		b1 = '{5'd6, 5'd5, 5'd5, 5'd6, 5'd5, 5'd6, 5'd6, 5'd5, 5'd6, 5'd5, 5'd5, 5'd6};
		b2 = '{5'd7, 5'd6, 5'd6, 5'd7, 5'd6, 5'd5, 5'd5, 5'd6, 5'd5, 5'd6, 5'd6, 5'd5};
		for (int i = 0; i < 12; i++) begin
			k = i / 2;
			send(enc_b((i % 2) ? 13'h1ff0 : 13'h0010, b2[i], b1[i],
				(k < 2) ? k[2:0] : k[2:0] + 3'd2));
		end
		end_test();

		begin_test("stores");
		load_const(5'd1, 32'h0000_2000);
		load_const(5'd2, $random(seed));
		send(enc_s(12'h003, 5'd2, 5'd1, f3_sb));
		send(enc_s(12'hffe, 5'd2, 5'd1, f3_sh));
		send(enc_s(12'h7fc, 5'd2, 5'd1, f3_sw));
		end_test();

		begin_test("csr and x0");
		send(enc_i(12'h305, 5'd2, f3_csrrw, 5'd8, opc_system));
		send(enc_i(12'h305, 5'd0, f3_csrrs, 5'd9, opc_system)); // read back
		send(enc_i(12'h300, 5'd1, f3_csrrs, 5'd10, opc_system));
		send(enc_i(12'h300, 5'd2, f3_csrrs, 5'd11, opc_system));
		send(enc_i(12'h300, 5'd0, f3_csrrs, 5'd12, opc_system));
		send(enc_i(12'h7c0, 5'd2, f3_csrrw, 5'd13, opc_system)); // unknown csr
		send(enc_i(12'h7c0, 5'd0, f3_csrrs, 5'd14, opc_system));
		send(enc_i(12'h007, 5'd2, 3'd0, 5'd0, opc_op_imm)); // addi x0
		send(enc_s(12'h000, 5'd0, 5'd0, f3_sw));
		end_test();

		begin_test("handshake timing");
		hold_ack = 1'b1;
		repeat (2) @(negedge clk);
		raise_req(enc_r(7'h00, 5'd2, 5'd1, 3'd0, 5'd15));
		k = 0;
		while (!inst_ack && k < 10) begin
			@(negedge clk);
			k++;
		end
		check_value("inst_ack latency", 3, k);
		check_value("commit_req", 1, commit_req);
		c0 = commit;
		inst_req = 1'b0;
		repeat (6) begin
			@(negedge clk);
			n_checks++;
			assert (commit === c0) else begin
				$display("commit record changed while commit_ack was held low");
				errors++;
			end
			check_value("inst_ack", 1, inst_ack);
		end
		commit_ack = 1'b1; // output handshake left open
		while (inst_ack) @(negedge clk);
		raise_req(enc_r(7'h00, 5'd1, 5'd15, 3'd0, 5'd16));
		repeat (6) begin
			@(negedge clk);
			check_value("inst_ack", 0, inst_ack);
		end
		commit_ack = 1'b0;
		hold_ack = 1'b0;
		while (!inst_ack) @(negedge clk);
		inst_req = 1'b0;
		while (inst_ack || commit_ack) @(negedge clk);
		check_value("inst_ack rises", n_sent, ack_rises);
		end_test();

		$display("checks %0d, errors %0d, instructions %0d", n_checks, errors, n_sent);
		if (errors == 0) begin
			$display("Everything OK");
		end else begin
			$display("Something failed");
		end
		$finish;
	end

endmodule

/* rv_exec.f */
+incdir+design
design/rv_isa_pkg.sv
design/rv_exec_pkg.sv
design/rv_idu.sv
design/rv_regfile.sv
design/rv_csr_file.sv
design/rv_exu.sv
design/rv_exec_ctrl.sv
design/rv_exec_top.sv
verif/rv_exec_clkgen.sv
verif/rv_exec_tb.sv

/* Bender.yml */
package:
  name: rv_exec

sources:
  - include_dirs:
      - design
    files:
      - design/rv_isa_pkg.sv
      - design/rv_exec_pkg.sv
      - design/rv_idu.sv
      - design/rv_regfile.sv
      - design/rv_csr_file.sv
      - design/rv_exu.sv
      - design/rv_exec_ctrl.sv
      - design/rv_exec_top.sv
  - target: test
    files:
      - verif/rv_exec_clkgen.sv
      - verif/rv_exec_tb.sv
